// ==== dv/scope_assert.sv ====
// protocol assertions bound into the top level
// held valid keeps its data at the decimator output and at sto
// the sw trigger pulse lasts one cycle
`timescale 1ns/100ps
`default_nettype none

module scope_assert (
  input logic               clk,
  input logic               rstn,
  input scope_pkg::stream_t dec_sto,
  input logic               dec_vld,
  input logic               dec_rdy,
  input scope_pkg::stream_t sto,
  input logic               sto_vld,
  input logic               sto_rdy,
  input logic               trg_swo
);

  // output held under back-pressure
  a_sto_hold: assert property (@(posedge clk) disable iff (!rstn)
    sto_vld && !sto_rdy |=> sto_vld && $stable(sto)) else $error("sto dropped or changed");

  // decimator to capture stage boundary
  a_dec_hold: assert property (@(posedge clk) disable iff (!rstn)
    dec_vld && !dec_rdy |=> dec_vld && $stable(dec_sto))
    else $error("decimated sample dropped or changed while held");

  a_swo_pulse: assert property (@(posedge clk) disable iff (!rstn)
    trg_swo |=> !trg_swo) else $error("sw trigger pulse longer than one cycle");

endmodule

bind scope_top scope_assert u_assert (
  .clk, .rstn,
  .dec_sto (std),
  .dec_vld (std_vld),
  .dec_rdy (std_rdy),
  .sto, .sto_vld, .sto_rdy, .trg_swo
);

`default_nettype wire

// ==== dv/scope_checker.sv ====
// monitor for the acquisition core sampled at the falling edge
// where the registered dut outputs are settled
// a transfer seen at a falling edge completes at the next rising edge
`timescale 1ns/100ps
`default_nettype none

module scope_checker #(
  parameter int CYC_LIMIT = 10000
) (
  input  logic               clk,
  input  logic               rstn,
  input  logic               sti_vld,
  input  logic               sti_rdy,
  input  scope_pkg::stream_t sto,
  input  logic               sto_vld,
  input  logic               sto_rdy,
  input  logic [1:0]         trg_out,
  input  logic               trg_swo,
  output int                 err_cnt,
  output int                 out_cnt,
  output int                 pend,      // expected outputs not yet seen
  output int                 swo_cnt,   // cycles with the sw trigger pulse high
  output logic               timed_out
);

  import scope_pkg::*;

  logic [$bits(stream_t)-1:0] out_q[$];   // expected {value, last}
  logic [1:0]                 edge_q[$];  // expected pulses per input transfer
  string      test_name = "none";
  logic [1:0] edge_due;   // pulses due this cycle
  int         cyc;
  int         stream_err = 0;
  int         misc_err   = 0;

  assign err_cnt = stream_err + misc_err;
  assign pend    = out_q.size();

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic push_out(input logic [$bits(stream_t)-1:0] item);
    out_q.push_back(item);
  endtask

  task automatic push_edge(input logic [1:0] p);
    edge_q.push_back(p);
  endtask

  task automatic compare(input string what, input reg_t exp, input reg_t act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
      misc_err = misc_err + 1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stream and edge compare
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rstn) begin
      edge_due = 2'b00;
      out_cnt  = 0;
      swo_cnt  = 0;
    end else begin
      if (trg_swo) swo_cnt = swo_cnt + 1;
      if (trg_out !== edge_due) begin  // pulse one cycle after the transfer
        $display("ERROR %s trg_out: expected %b actual %b", test_name, edge_due, trg_out);
        stream_err = stream_err + 1;
      end
      edge_due = 2'b00;
      if (sti_vld && sti_rdy) begin
        if (edge_q.size() == 0) begin
          $display("input transfer in %s that the testbench never drove", test_name);
          stream_err = stream_err + 1;
        end else edge_due = edge_q.pop_front();
      end
      if (sto_vld && out_q.size() == 0) begin
        $display("unexpected sto_vld in %s with no output pending", test_name);
        stream_err = stream_err + 1;
      end else if (sto_vld && sto_rdy) begin
        if (out_q[0] !== sto) begin
          $display("ERROR %s out %0d: expected %h actual %h", test_name, out_cnt,
                   out_q[0], sto);
          stream_err = stream_err + 1;
        end
        void'(out_q.pop_front());
        out_cnt = out_cnt + 1;
      end
    end
  end

  // timeout
  always @(posedge clk) begin
    if (!rstn) begin
      cyc       <= 0;
      timed_out <= 1'b0;
    end else begin
      cyc       <= cyc + 1;
      timed_out <= (cyc >= CYC_LIMIT);
    end
  end

endmodule

`default_nettype wire

// ==== dv/scope_tb.sv ====
// testbench for the acquisition core with apb setup and random and ramp streams
// inputs change 1ns after the rising edge and sto_rdy is throttled at random
// expected outputs and edge pulses come from the reference functions below
`timescale 1ns/100ps
`default_nettype none

`include "scope_cfg.svh"

module scope_tb;

  import scope_pkg::*;

  localparam int N_SMP     = 200;               // samples over all streams
  localparam int CYC_LIMIT = N_SMP * 16 + 2000;  // throttled stream plus apb

  logic                     clk, rstn;
  logic                     psel, penable, pwrite;
  logic [`SCOPE_ADDR_W-1:0] paddr;
  reg_t                     pwdata, prdata;
  logic                     pready;
  stream_t                  sti, sto;
  logic                     sti_vld, sti_rdy, sto_vld, sto_rdy;
  logic [`SCOPE_EXT_W-1:0]  trg_ext;
  logic                     trg_swo;
  logic [1:0]               trg_out;
  int                       err_cnt, out_cnt, pend, swo_cnt;
  logic                     timed_out;

  int   seed = 32'h8dac_f2ad;
  int   pool[0:255];   // random samples drawn once at time 0
  int   pool_pos;
  int   smp[0:127];    // current stream
  logic [1:0] eexp[0:127];  // expected {neg, pos} per sample
  logic throttle;
  int   c_dec, c_shr, c_lvl, c_hst;  // mirrors of the programmed config
  bit   c_avg;
  bit   arm_p, arm_n;  // reference schmitt state
  reg_t rd;
  int   trg_idx;
  int   swo_exp;       // sw trigger writes issued

  scope_top u_scope_top (.*);

  scope_checker #(.CYC_LIMIT(CYC_LIMIT)) u_chk (
    .clk, .rstn, .sti_vld, .sti_rdy, .sto, .sto_vld, .sto_rdy, .trg_out, .trg_swo,
    .err_cnt, .out_cnt, .pend, .swo_cnt, .timed_out
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns

  // random back-pressure with roughly 3 of 4 cycles ready
  always @(posedge clk) begin
    #1;
    if (throttle) sto_rdy = ($random(seed) % 4) != 0;
    else          sto_rdy = 1'b1;
  end

  always @(posedge clk) begin
    if (timed_out) begin
      $display("timeout: run did not finish within %0d cycles", CYC_LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // window k of the current stream after decimation/averaging
  function automatic int dec_ref(input int k);
    int sum;
    int d;
    d   = (c_dec == 0) ? 1 : c_dec;
    sum = 0;
    for (int i = 0; i < d; i++) sum += smp[k*d + i];
    if (c_avg) return sum >>> c_shr;
    return smp[k*d + d - 1];
  endfunction

  // one input sample through the two-sided schmitt trigger, returns {neg, pos}
  function automatic logic [1:0] edge_ref(input int v);
    int lo, hi;
    logic [1:0] p;
    p  = 2'b00;
    lo = c_lvl - c_hst;
    hi = c_lvl + c_hst;
    if (lo < -8192) lo = -8192;  // saturate at the 14 bit range
    if (hi > 8191)  hi = 8191;
    if (v < lo) arm_p = 1'b1;
    else if (arm_p && v >= hi) begin
      p[0]  = 1'b1;
      arm_p = 1'b0;
    end
    if (v > hi) arm_n = 1'b1;
    else if (arm_n && v <= lo) begin
      p[1]  = 1'b1;
      arm_n = 1'b0;
    end
    return p;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // apb and stream tasks
  //////////////////////////////////////////////////////////////////////

  task automatic apb_write(input logic [`SCOPE_ADDR_W-1:0] addr, input reg_t data);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    u_chk.compare("pready on write", 1, reg_t'(pready));
    if (addr == `SCOPE_REG_CTL && data[1]) swo_exp = swo_exp + 1;
    @(posedge clk);
    #1;  // write lands on this edge
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [`SCOPE_ADDR_W-1:0] addr, output reg_t data);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    u_chk.compare("pready on read", 1, reg_t'(pready));
    data = prdata;  // mid cycle where status is settled
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic configure(input bit avg, input int dec, input int shr, input int sel,
                           input int dly);
    apb_write(`SCOPE_REG_CFG_AVG, reg_t'(avg));
    apb_write(`SCOPE_REG_CFG_DEC, reg_t'(dec));
    apb_write(`SCOPE_REG_CFG_SHR, reg_t'(shr));
    apb_write(`SCOPE_REG_CFG_SEL, reg_t'(sel));
    apb_write(`SCOPE_REG_CFG_DLY, reg_t'(dly));
    c_avg = avg;
    c_dec = dec;
    c_shr = shr;
  endtask

  task automatic set_level(input int lvl, input int hst);
    apb_write(`SCOPE_REG_CFG_LVL, reg_t'(lvl));
    apb_write(`SCOPE_REG_CFG_HST, reg_t'(hst));
    c_lvl = lvl;
    c_hst = hst;
  endtask

  task automatic fill_random(input int n);
    for (int i = 0; i < n; i++) begin
      smp[i]   = pool[pool_pos];
      pool_pos = pool_pos + 1;
    end
  endtask

  // run the reference edge model over the stream in transfer order
  task automatic load_edges(input int n);
    for (int i = 0; i < n; i++) eexp[i] = edge_ref(smp[i]);
  endtask

  task automatic expect_windows(input int k0, input int k1, input int last_k);
    for (int k = k0; k <= k1; k++) u_chk.push_out({sample_t'(dec_ref(k)), k == last_k});
  endtask

  // valid held until accepted with data stable meanwhile
  task automatic send_range(input int from, input int to);
    for (int i = from; i < to; i++) begin
      u_chk.push_edge(eexp[i]);
      sti.value = sample_t'(smp[i]);
      sti.last  = 1'b0;
      sti_vld   = 1'b1;
      do @(negedge clk); while (!sti_rdy);
      @(posedge clk);
      #1;
      sti_vld = 1'b0;
    end
  endtask

  task automatic drain();
    while (pend != 0) @(posedge clk);
    repeat (20) @(posedge clk);
    #1;
  endtask

  task automatic check_read(input logic [`SCOPE_ADDR_W-1:0] addr, input reg_t exp,
                            input string what);
    apb_read(addr, rd);
    u_chk.compare(what, exp, rd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  initial begin
    rstn     = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    sti      = '0;
    sti_vld  = 1'b0;
    sto_rdy  = 1'b1;
    trg_ext  = '0;
    throttle = 1'b1;
    arm_p    = 1'b0;
    arm_n    = 1'b0;
    pool_pos = 0;
    swo_exp  = 0;
    c_avg    = 1'b0;
    c_dec    = 0;
    c_shr    = 0;
    c_lvl    = 0;
    c_hst    = 0;
    for (int i = 0; i < 256; i++) pool[i] = $random(seed) % 8192;
    repeat (4) @(posedge clk);
    #1 rstn = 1'b1;

    // register readback
    u_chk.set_test("regs");
    configure(1'b1, 32'h1abcd, 10, 32'hb, 32'h1234_5678);
    set_level(-100, 32'h155);
    apb_write(6'h30, 32'hdead_beef);
    check_read(`SCOPE_REG_CFG_AVG, 32'h1, "avg");
    check_read(`SCOPE_REG_CFG_DEC, 32'h1abcd, "dec");
    check_read(`SCOPE_REG_CFG_SHR, 32'ha, "shr");
    check_read(`SCOPE_REG_CFG_SEL, 32'hb, "sel");
    check_read(`SCOPE_REG_CFG_DLY, 32'h1234_5678, "dly");
    check_read(`SCOPE_REG_CFG_LVL, 32'hffff_ff9c, "lvl");
    check_read(`SCOPE_REG_CFG_HST, 32'h155, "hst");
    check_read(6'h30, 32'h0, "unmapped 0x30");
    check_read(6'h04, 32'h0, "unmapped 0x04");

    // plain decimation with sw trigger after window 2
    u_chk.set_test("plain_dec");
    configure(1'b0, 4, 0, 0, 5);
    apb_write(`SCOPE_REG_CTL, 32'h4);
    fill_random(44);
    load_edges(44);
    expect_windows(0, 2, -1);
    send_range(0, 12);
    drain();
    apb_write(`SCOPE_REG_CTL, 32'h2);
    expect_windows(3, 7, 7);  // five more and the fifth with last
    send_range(12, 44);
    drain();
    check_read(`SCOPE_REG_CTL, 32'h0, "sts after last");

    // averaging under back-pressure
    u_chk.set_test("avg");
    configure(1'b1, 8, 3, 0, 6);
    apb_write(`SCOPE_REG_CTL, 32'h4);
    fill_random(80);
    load_edges(80);
    expect_windows(0, 1, -1);
    send_range(0, 16);
    drain();
    apb_write(`SCOPE_REG_CTL, 32'h2);
    expect_windows(2, 7, 7);
    send_range(16, 80);
    drain();

    // ramp and fall through the edge detector with trigger on the rising edge
    u_chk.set_test("edge");
    throttle = 1'b0;  // keeps the trigger point fixed
    set_level(100, 20);
    configure(1'b0, 1, 0, 1, 4);
    apb_write(`SCOPE_REG_CTL, 32'h4);
    for (int j = 0; j < 40; j++) smp[j] = (j < 20) ? -200 + 30*j : 370 - 40*(j-20);
    load_edges(40);
    trg_idx = -1;
    for (int j = 39; j >= 0; j--) if (eexp[j][0]) trg_idx = j;
    expect_windows(0, trg_idx + 4, trg_idx + 4);
    send_range(0, 40);
    drain();
    throttle = 1'b1;

    // external trigger bit 2
    u_chk.set_test("ext");
    configure(1'b0, 2, 0, 32'hb, 3);
    apb_write(`SCOPE_REG_CTL, 32'h4);
    fill_random(14);
    load_edges(14);
    expect_windows(0, 1, -1);
    send_range(0, 4);
    drain();
    trg_ext = 4'b0100;
    @(posedge clk);
    #1;
    trg_ext = 4'b0000;
    expect_windows(2, 4, 4);
    send_range(4, 14);
    drain();
    check_read(`SCOPE_REG_CTL, 32'h0, "sts after ext");

    // clear in the middle of a capture and nothing may follow
    u_chk.set_test("clr");
    configure(1'b0, 2, 0, 0, 100);
    apb_write(`SCOPE_REG_CTL, 32'h4);
    fill_random(16);
    load_edges(16);
    expect_windows(0, 2, -1);
    send_range(0, 6);
    drain();
    apb_write(`SCOPE_REG_CTL, 32'h1);
    check_read(`SCOPE_REG_CTL, 32'h0, "sts after clr");
    send_range(6, 16);
    drain();

    // one trg_swo cycle per sw trigger write
    u_chk.set_test("swo");
    u_chk.compare("sw trigger pulses", reg_t'(swo_exp), reg_t'(swo_cnt));
    @(posedge clk);

    $display("errors %0d, output transfers %0d", err_cnt, out_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/scope_acq.sv ====
// arm, trigger and post-trigger count on the decimated stream
// after the trigger cfg.dly samples pass, the one ending the count has last
// a dly of 0 behaves as 1; samples outside a capture are dropped
// clr aborts a capture and drops a held output
`timescale 1ns/100ps
`default_nettype none

`include "scope_cfg.svh"

module scope_acq (
  input  logic                     clk,
  input  logic                     rstn,
  // control and trigger sources
  input  logic                     clr,
  input  logic                     arm,
  input  logic                     sw_trg,
  input  logic                     trg_pos,
  input  logic                     trg_neg,
  input  logic [`SCOPE_EXT_W-1:0]  trg_ext,
  input  scope_pkg::scope_cfg_t    cfg,
  // decimated stream in
  input  scope_pkg::stream_t       sti,
  input  logic                     sti_vld,
  output logic                     sti_rdy,
  // output stream
  output scope_pkg::stream_t       sto,
  output logic                     sto_vld,
  input  logic                     sto_rdy,
  // status
  output logic                     sts_acq,
  output logic                     sts_trg
);

  import scope_pkg::*;

  typedef enum logic [1:0] {st_idle, st_acq, st_trg} state_e;

  state_e state;
  dly_t   cnt;      // post-trigger samples left
  logic   trg_mux;  // selected trigger
  logic   xfer;
  logic   pass;     // accepted and forwarded
  logic   cnt_end;  // this sample ends the count

  // trigger source mux, port names shadow the enum values
  always_comb begin
    unique case (cfg.src)
      scope_pkg::trg_sw:  trg_mux = sw_trg;
      scope_pkg::trg_pos: trg_mux = trg_pos;
      scope_pkg::trg_neg: trg_mux = trg_neg;
      scope_pkg::trg_ext: trg_mux = trg_ext[cfg.ext_sel];
    endcase
  end

  assign sti_rdy = sto_rdy | ~sto_vld;  // one item held under back-pressure
  assign xfer    = sti_vld & sti_rdy;
  assign pass    = xfer & (state != st_idle);
  assign cnt_end = (cnt <= dly_t'(1));
  assign sts_acq = (state != st_idle);
  assign sts_trg = (state == st_trg);

  //////////////////////////////////////////////////////////////////////
  // fsm and output valid
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= st_idle;
      cnt     <= '0;
      sto_vld <= 1'b0;
    end else if (clr) begin
      state   <= st_idle;  // abort
      sto_vld <= 1'b0;
    end else begin
      case (state)
        st_idle: if (arm) state <= st_acq;
        st_acq: begin
          if (trg_mux) begin
            state <= st_trg;
            cnt   <= cfg.dly;
          end
        end
        st_trg: begin
          if (pass) begin
            if (cnt_end) state <= st_idle;  // capture done
            else         cnt   <= cnt - dly_t'(1);
          end
        end
        default: state <= st_idle;
      endcase
      if (pass)         sto_vld <= 1'b1;
      else if (sto_rdy) sto_vld <= 1'b0;
    end
  end

  // output payload
  always_ff @(posedge clk) begin
    if (pass) begin
      sto.value <= sti.value;
      sto.last  <= (state == st_trg) && cnt_end;
    end
  end

endmodule

`default_nettype wire

// ==== hw/scope_cfg.svh ====
// widths and register map shared by the rtl and the testbench
// register offsets are byte addresses inside a 64 byte apb window
// sample width must stay below 32, readback sign extends the level
`ifndef SCOPE_CFG_SVH
`define SCOPE_CFG_SVH

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////

`define SCOPE_DW      14  // adc sample, signed
`define SCOPE_DEC_W   17  // decimation counter
`define SCOPE_SHR_W   4   // averaging shift
`define SCOPE_EXT_W   4   // external trigger vector
`define SCOPE_ADDR_W  6   // apb address

//////////////////////////////////////////////////////////////////////
// register offsets
//////////////////////////////////////////////////////////////////////

`define SCOPE_REG_CTL      6'h00  // w: clr/sw_trg/arm pulses, r: status
`define SCOPE_REG_CFG_SEL  6'h08  // [1:0] source, [3:2] ext bit
`define SCOPE_REG_CFG_DLY  6'h0c  // post-trigger samples
`define SCOPE_REG_CFG_LVL  6'h10  // edge level, signed
`define SCOPE_REG_CFG_HST  6'h14  // hysteresis, unsigned
`define SCOPE_REG_CFG_AVG  6'h24  // averaging enable, bit 0
`define SCOPE_REG_CFG_DEC  6'h28  // decimation factor
`define SCOPE_REG_CFG_SHR  6'h2c  // right shift after sum

`endif

// ==== hw/scope_dec_avg.sv ====
// one output per cfg_dec accepted inputs, a factor of 0 behaves as 1
// with averaging the window sum is shifted right arithmetically by
// cfg_shr, no other scaling, the low bits of the result are kept
// clr restarts the window, an output already held is still delivered
`timescale 1ns/100ps
`default_nettype none

`include "scope_cfg.svh"

module scope_dec_avg (
  input  logic                clk,
  input  logic                rstn,
  input  logic                clr,      // window restart
  // configuration
  input  logic                cfg_avg,
  input  scope_pkg::dec_t     cfg_dec,
  input  scope_pkg::shr_t     cfg_shr,
  // input stream
  input  scope_pkg::stream_t  sti,
  input  logic                sti_vld,
  output logic                sti_rdy,
  // output stream
  output scope_pkg::stream_t  sto,
  output logic                sto_vld,
  input  logic                sto_rdy
);

  import scope_pkg::*;

  dec_t cnt;      // phase in the window
  acc_t acc;      // sum of the window so far
  acc_t sum;      // sum including the current sample
  acc_t sum_shr;
  logic xfer;
  logic win_end;  // current sample closes the window

  assign sti_rdy = sto_rdy | ~sto_vld;  // stall while output is held
  assign xfer    = sti_vld & sti_rdy;
  assign win_end = (cfg_dec == '0) || (cnt >= cfg_dec - dec_t'(1));

  assign sum     = acc + acc_t'(sti.value);  // sign extended
  assign sum_shr = sum >>> cfg_shr;

  //////////////////////////////////////////////////////////////////////
  // phase and accumulator
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt     <= '0;
      acc     <= '0;
      sto_vld <= 1'b0;
    end else begin
      if (clr) begin
        cnt <= '0;
        acc <= '0;
      end else if (xfer) begin
        if (win_end) begin
          cnt <= '0;  // next window
          acc <= '0;
        end else begin
          cnt <= cnt + dec_t'(1);
          acc <= sum;
        end
      end
      // output valid
      if (xfer && win_end && !clr) sto_vld <= 1'b1;
      else if (sto_rdy)             sto_vld <= 1'b0;
    end
  end

  // output payload, loaded at the end of each window
  always_ff @(posedge clk) begin
    if (xfer && win_end) begin
      sto.value <= cfg_avg ? sum_shr[`SCOPE_DW-1:0] : sti.value;
      sto.last  <= sti.last;
    end
  end

endmodule

`default_nettype wire

// ==== hw/scope_edge.sv ====
// two-sided schmitt trigger on accepted input samples
// thresholds lvl-hst and lvl+hst saturate at the sample range
// pulses come one cycle after the transfer that completes an edge
`timescale 1ns/100ps
`default_nettype none

`include "scope_cfg.svh"

module scope_edge (
  input  logic                  clk,
  input  logic                  rstn,
  // monitored stream
  input  scope_pkg::stream_t    sti,
  input  logic                  sti_vld,
  input  logic                  sti_rdy,
  // configuration
  input  scope_pkg::sample_t    cfg_lvl,
  input  logic [`SCOPE_DW-1:0]  cfg_hst,
  // edge pulses
  output logic                  trg_pos,
  output logic                  trg_neg
);

  import scope_pkg::*;

  typedef logic signed [`SCOPE_DW+1:0] wide_t;  // room for lvl +- hst

  localparam sample_t S_MAX = {1'b0, {(`SCOPE_DW-1){1'b1}}};
  localparam sample_t S_MIN = {1'b1, {(`SCOPE_DW-1){1'b0}}};

  wide_t   lo_w, hi_w;
  sample_t lo, hi;     // saturated thresholds
  logic    xfer;
  logic    arm_pos;    // seen a sample below lo
  logic    arm_neg;    // seen a sample above hi

  assign lo_w = wide_t'(cfg_lvl) - wide_t'({1'b0, cfg_hst});
  assign hi_w = wide_t'(cfg_lvl) + wide_t'({1'b0, cfg_hst});
  assign lo   = (lo_w < wide_t'(S_MIN)) ? S_MIN : lo_w[`SCOPE_DW-1:0];
  assign hi   = (hi_w > wide_t'(S_MAX)) ? S_MAX : hi_w[`SCOPE_DW-1:0];

  assign xfer = sti_vld & sti_rdy;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      arm_pos <= 1'b0;
      arm_neg <= 1'b0;
      trg_pos <= 1'b0;
      trg_neg <= 1'b0;
    end else begin
      trg_pos <= 1'b0;  // single cycle pulses
      trg_neg <= 1'b0;
      if (xfer) begin
        // rising edge: below lo, then reaching hi
        if (sti.value < lo) begin
          arm_pos <= 1'b1;
        end else if (arm_pos && sti.value >= hi) begin
          trg_pos <= 1'b1;
          arm_pos <= 1'b0;
        end
        // falling edge, mirrored
        if (sti.value > hi) begin
          arm_neg <= 1'b1;
        end else if (arm_neg && sti.value <= lo) begin
          trg_neg <= 1'b1;
          arm_neg <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/scope_pkg.sv ====
// types for the acquisition pipeline and its register block
// widths come from the cfg header, external select width is derived
`default_nettype none

`include "scope_cfg.svh"

package scope_pkg;

  // plain vectors with a meaning
  typedef logic signed [`SCOPE_DW-1:0]              sample_t;  // adc sample
  typedef logic signed [`SCOPE_DW+`SCOPE_DEC_W-1:0] acc_t;     // window sum
  typedef logic        [`SCOPE_DEC_W-1:0]           dec_t;     // decimation factor
  typedef logic        [`SCOPE_SHR_W-1:0]           shr_t;     // shift amount
  typedef logic        [31:0]                       dly_t;     // post-trigger count
  typedef logic        [31:0]                       reg_t;     // apb data word

  localparam int unsigned EXT_SEL_W = $clog2(`SCOPE_EXT_W);

  // trigger source select, encoding matches CFG_SEL[1:0]
  typedef enum logic [1:0] {
    trg_sw  = 2'd0,
    trg_pos = 2'd1,
    trg_neg = 2'd2,
    trg_ext = 2'd3
  } trg_src_e;

  // one stream beat
  typedef struct packed {
    sample_t value;
    logic    last;  // final sample of a capture
  } stream_t;

  // configuration from the register block
  typedef struct packed {
    logic                   avg;      // averaging on
    dec_t                   dec;
    shr_t                   shr;
    sample_t                lvl;      // edge level
    logic [`SCOPE_DW-1:0]   hst;      // hysteresis, unsigned
    trg_src_e               src;
    logic [EXT_SEL_W-1:0]   ext_sel;  // bit of trg_ext
    dly_t                   dly;
  } scope_cfg_t;

endpackage

`default_nettype wire

// ==== hw/scope_regs.sv ====
// apb slave, zero wait states, no error response
// control pulses are combinational, high during the write access phase
// CFG_SEL holds the source in [1:0] and the external bit in [3:2]
// unmapped offsets read zero, writes to them are ignored
`timescale 1ns/100ps
`default_nettype none

`include "scope_cfg.svh"

module scope_regs (
  input  logic                      clk,
  input  logic                      rstn,
  // apb
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`SCOPE_ADDR_W-1:0]  paddr,
  input  scope_pkg::reg_t           pwdata,
  output scope_pkg::reg_t           prdata,
  output logic                      pready,
  // configuration to all stages
  output scope_pkg::scope_cfg_t     cfg,
  // control pulses
  output logic                      clr,
  output logic                      arm,
  output logic                      sw_trg,
  // status
  input  logic                      sts_acq,
  input  logic                      sts_trg
);

  import scope_pkg::*;

  logic wr;      // access phase write
  logic rd;      // access phase read
  logic wr_ctl;  // write to control
  reg_t rd_dat;

  assign wr     = psel & penable & pwrite;
  assign rd     = psel & penable & ~pwrite;
  assign pready = 1'b1;  // never stalls

  //////////////////////////////////////////////////////////////////////
  // control pulses
  //////////////////////////////////////////////////////////////////////

  assign wr_ctl = wr & (paddr == `SCOPE_REG_CTL);
  assign clr    = wr_ctl & pwdata[0];
  assign sw_trg = wr_ctl & pwdata[1];
  assign arm    = wr_ctl & pwdata[2];

  //////////////////////////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg <= '0;  // source sw, everything off
    end else if (wr) begin
      case (paddr)
        `SCOPE_REG_CFG_SEL: begin
          cfg.src     <= trg_src_e'(pwdata[1:0]);
          cfg.ext_sel <= pwdata[2 +: EXT_SEL_W];
        end
        `SCOPE_REG_CFG_DLY: cfg.dly <= pwdata;
        `SCOPE_REG_CFG_LVL: cfg.lvl <= pwdata[`SCOPE_DW-1:0];
        `SCOPE_REG_CFG_HST: cfg.hst <= pwdata[`SCOPE_DW-1:0];
        `SCOPE_REG_CFG_AVG: cfg.avg <= pwdata[0];
        `SCOPE_REG_CFG_DEC: cfg.dec <= pwdata[`SCOPE_DEC_W-1:0];
        `SCOPE_REG_CFG_SHR: cfg.shr <= pwdata[`SCOPE_SHR_W-1:0];
        default: ;  // ctl and holes
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_dat = '0;
    case (paddr)
      `SCOPE_REG_CTL:     rd_dat = reg_t'({sts_acq, sts_trg, 1'b0});
      `SCOPE_REG_CFG_SEL: rd_dat = reg_t'({cfg.ext_sel, cfg.src});
      `SCOPE_REG_CFG_DLY: rd_dat = cfg.dly;
      `SCOPE_REG_CFG_LVL: begin
        // level is signed, extend the sign
        rd_dat = {{($bits(reg_t)-`SCOPE_DW){cfg.lvl[`SCOPE_DW-1]}}, cfg.lvl};
      end
      `SCOPE_REG_CFG_HST: rd_dat = reg_t'(cfg.hst);
      `SCOPE_REG_CFG_AVG: rd_dat = reg_t'(cfg.avg);
      `SCOPE_REG_CFG_DEC: rd_dat = reg_t'(cfg.dec);
      `SCOPE_REG_CFG_SHR: rd_dat = reg_t'(cfg.shr);
      default:            rd_dat = '0;
    endcase
  end

  assign prdata = rd ? rd_dat : '0;  // only driven in the access phase

endmodule

`default_nettype wire

// ==== hw/scope_top.sv ====
// oscilloscope acquisition core: apb registers, edge trigger,
// decimator and capture stage, no correction filter
// samples leave as a ready/valid stream, there is no capture memory
// trg_out[0] is the positive edge pulse, trg_out[1] the negative one
`timescale 1ns/100ps
`default_nettype none

`include "scope_cfg.svh"

module scope_top (
  input  logic                      clk,
  input  logic                      rstn,
  // apb
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`SCOPE_ADDR_W-1:0]  paddr,
  input  scope_pkg::reg_t           pwdata,
  output scope_pkg::reg_t           prdata,
  output logic                      pready,
  // adc stream
  input  scope_pkg::stream_t        sti,
  input  logic                      sti_vld,
  output logic                      sti_rdy,
  // capture stream
  output scope_pkg::stream_t        sto,
  output logic                      sto_vld,
  input  logic                      sto_rdy,
  // triggers
  input  logic [`SCOPE_EXT_W-1:0]   trg_ext,
  output logic                      trg_swo,  // sw trigger pulse
  output logic [1:0]                trg_out   // edge pulses
);

  import scope_pkg::*;

  scope_cfg_t cfg;
  logic       clr, arm;
  logic       sts_acq, sts_trg;
  stream_t    std;      // decimated stream
  logic       std_vld, std_rdy;

  scope_regs u_regs (
    .clk, .rstn,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
    .cfg,
    .clr, .arm,
    .sw_trg  (trg_swo),
    .sts_acq, .sts_trg
  );

  // edge detector taps the raw input
  scope_edge u_edge (
    .clk, .rstn,
    .sti, .sti_vld, .sti_rdy,
    .cfg_lvl (cfg.lvl),
    .cfg_hst (cfg.hst),
    .trg_pos (trg_out[0]),
    .trg_neg (trg_out[1])
  );

  scope_dec_avg u_dec (
    .clk, .rstn,
    .clr     (clr | arm),  // window restarts on both
    .cfg_avg (cfg.avg),
    .cfg_dec (cfg.dec),
    .cfg_shr (cfg.shr),
    .sti, .sti_vld, .sti_rdy,
    .sto     (std),
    .sto_vld (std_vld),
    .sto_rdy (std_rdy)
  );

  scope_acq u_acq (
    .clk, .rstn,
    .clr, .arm,
    .sw_trg  (trg_swo),
    .trg_pos (trg_out[0]),
    .trg_neg (trg_out[1]),
    .trg_ext, .cfg,
    .sti     (std),
    .sti_vld (std_vld),
    .sti_rdy (std_rdy),
    .sto, .sto_vld, .sto_rdy,
    .sts_acq, .sts_trg
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module scope_tb -f verilog.f -o scope_sim

out=$(./obj_dir/scope_sim)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED"

// ==== verilog.f ====
+incdir+hw
hw/scope_pkg.sv
hw/scope_regs.sv
hw/scope_dec_avg.sv
hw/scope_edge.sv
hw/scope_acq.sv
hw/scope_top.sv
dv/scope_assert.sv
dv/scope_checker.sv
dv/scope_tb.sv
